// File: list.f
sdram_pkg.sv
sdram_cfg_regs.sv
sdram_delay_timer.sv
sdram_cmd_fsm.sv
sdram_seq_top.sv
sdram_seq_checker.sv
tb_sdram_seq.sv

// File: sdram_cfg_regs.sv
module sdram_cfg_regs (
	input  logic                     clk,
	input  logic                     rst,
	input  sdram_pkg::axil_req_t     axil_req_i,
	input  logic                     init_done_i,
	output sdram_pkg::axil_rsp_t     axil_rsp_o,
	output sdram_pkg::sdram_timing_t timing_o,
	output sdram_pkg::sdram_addr_t   mode_o,
	output logic                     init_start_o
);

	logic wr_fire;
	logic rd_fire;
	logic bvalid_q;
	logic rvalid_q;
	logic init_start_q;
	sdram_pkg::axil_data_t rdata_q;
	sdram_pkg::axil_data_t rd_mux;
	sdram_pkg::axil_data_t timing_wr;
	sdram_pkg::axil_data_t mode_wr;
	sdram_pkg::sdram_timing_t timing_q;
	sdram_pkg::sdram_addr_t mode_q;

	// One write or read outstanding at a time
	assign wr_fire = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
	assign rd_fire = axil_req_i.arvalid && !rvalid_q;

	// Merge write data under byte strobes
	always_comb
	begin
		timing_wr = timing_q;
		mode_wr = 32'(mode_q);
		for (int i = 0; i < 4; i++)
		begin
			if (axil_req_i.wstrb[i])
			begin
				timing_wr[8*i +: 8] = axil_req_i.wdata[8*i +: 8];
				mode_wr[8*i +: 8] = axil_req_i.wdata[8*i +: 8];
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			timing_q <= '1;	// Slowest timing until programmed
			mode_q <= '0;
			init_start_q <= 1'b0;
		end
		else
		begin
			init_start_q <= wr_fire && axil_req_i.awaddr == sdram_pkg::REG_CTRL &&
				axil_req_i.wstrb[0] && axil_req_i.wdata[0];
			if (wr_fire && axil_req_i.awaddr == sdram_pkg::REG_TIMING)
				timing_q <= timing_wr;
			if (wr_fire && axil_req_i.awaddr == sdram_pkg::REG_MODE)
				mode_q <= mode_wr[12:0];
		end
	end

	// Write response
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			bvalid_q <= 1'b0;
		else if (wr_fire)
			bvalid_q <= 1'b1;
		else if (axil_req_i.bready)
			bvalid_q <= 1'b0;
	end

	always_comb
	begin
		case (axil_req_i.araddr)
			sdram_pkg::REG_TIMING: rd_mux = timing_q;
			sdram_pkg::REG_MODE:   rd_mux = 32'(mode_q);
			sdram_pkg::REG_CTRL:   rd_mux = {30'b0, init_done_i, 1'b0};
			default:               rd_mux = '0;	// Unmapped
		endcase
	end

	// Read data channel
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			rvalid_q <= 1'b0;
		else if (rd_fire)
			rvalid_q <= 1'b1;
		else if (axil_req_i.rready)
			rvalid_q <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (rd_fire)
			rdata_q <= rd_mux;
	end

	always_comb
	begin
		axil_rsp_o.awready = wr_fire;	// Both ready together
		axil_rsp_o.wready = wr_fire;
		axil_rsp_o.bvalid = bvalid_q;
		axil_rsp_o.bresp = sdram_pkg::RESP_OKAY;
		axil_rsp_o.arready = rd_fire;
		axil_rsp_o.rvalid = rvalid_q;
		axil_rsp_o.rdata = rdata_q;
		axil_rsp_o.rresp = sdram_pkg::RESP_OKAY;
	end

	assign timing_o = timing_q;
	assign mode_o = mode_q;
	assign init_start_o = init_start_q;

endmodule

// File: sdram_cmd_fsm.sv
module sdram_cmd_fsm (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   init_start_i,
	input  sdram_pkg::sdram_addr_t mode_i,
	input  logic                   host_req_valid_i,
	input  sdram_pkg::host_req_t   host_req_i,
	input  logic                   rfr_req_i,
	input  logic                   tmr_done_i,
	input  logic                   irc_done_i,
	output logic                   host_ack_o,
	output logic                   rfr_ack_o,
	output logic                   init_done_o,
	output sdram_pkg::sdram_cmd_t  cmd_o,
	output sdram_pkg::timer_sel_e  tmr_sel_o,
	output logic                   irc_load_o,
	output logic                   irc_dec_o
);

	typedef enum logic [4:0] {
		IDLE,
		INIT_PALL, INIT_PALL_W, INIT_REF, INIT_REF_W, INIT_LMR, INIT_LMR_W,
		RFR_PALL, RFR_PALL_W, RFR_REF, RFR_REF_W,
		ACT, ACT_W, RD, RD_W, WR, RECOVER_W
	} state_e;

	state_e state_q, state_d;
	sdram_pkg::sdram_cmd_t cmd_d, cmd_q;
	sdram_pkg::host_req_t req_q;
	logic req_ld;
	logic host_ack_d, host_ack_q;
	logic rfr_ack_d, rfr_ack_q;
	logic init_set, init_clr, init_done_q;

	always_comb
	begin
		state_d = state_q;
		cmd_d = sdram_pkg::CMD_NOP;
		tmr_sel_o = sdram_pkg::NONE;
		irc_load_o = 1'b0;
		irc_dec_o = 1'b0;
		host_ack_d = 1'b0;
		rfr_ack_d = 1'b0;
		req_ld = 1'b0;
		init_set = 1'b0;
		init_clr = 1'b0;

		case (state_q)
			IDLE:
			begin
				if (init_start_i)
				begin
					init_clr = 1'b1;
					state_d = INIT_PALL;
				end
				else if (init_done_q && rfr_req_i)	// Refresh wins over access
					state_d = RFR_PALL;
				else if (init_done_q && host_req_valid_i)
				begin
					req_ld = 1'b1;
					state_d = ACT;
				end
			end

			////////////////////////////////
			// Initialization

			INIT_PALL:
			begin
				cmd_d.op = sdram_pkg::PRECHARGE;
				cmd_d.addr = sdram_pkg::ADDR_AP;
				tmr_sel_o = sdram_pkg::TRP;
				irc_load_o = 1'b1;
				state_d = INIT_PALL_W;
			end
			INIT_PALL_W: if (tmr_done_i) state_d = INIT_REF;
			INIT_REF:
			begin
				cmd_d.op = sdram_pkg::AUTO_REFRESH;
				tmr_sel_o = sdram_pkg::TRFC;
				irc_dec_o = 1'b1;
				state_d = INIT_REF_W;
			end
			INIT_REF_W:
			begin
				if (tmr_done_i)
					state_d = irc_done_i ? INIT_LMR : INIT_REF;
			end
			INIT_LMR:
			begin
				cmd_d.op = sdram_pkg::LOAD_MODE;
				cmd_d.addr = mode_i;
				tmr_sel_o = sdram_pkg::TRFC;
				state_d = INIT_LMR_W;
			end
			INIT_LMR_W:
			begin
				if (tmr_done_i)
				begin
					init_set = 1'b1;
					state_d = IDLE;
				end
			end

			////////////////////////////////
			// Requested refresh

			RFR_PALL:
			begin
				cmd_d.op = sdram_pkg::PRECHARGE;
				cmd_d.addr = sdram_pkg::ADDR_AP;
				tmr_sel_o = sdram_pkg::TRP;
				state_d = RFR_PALL_W;
			end
			RFR_PALL_W: if (tmr_done_i) state_d = RFR_REF;
			RFR_REF:
			begin
				cmd_d.op = sdram_pkg::AUTO_REFRESH;
				tmr_sel_o = sdram_pkg::TRFC;
				rfr_ack_d = 1'b1;	// Lines up with the command
				state_d = RFR_REF_W;
			end
			RFR_REF_W: if (tmr_done_i) state_d = IDLE;

			////////////////////////////////
			// Single word access, closed page

			ACT:
			begin
				cmd_d.op = sdram_pkg::ACTIVATE;
				cmd_d.bank = req_q.bank;
				cmd_d.addr = req_q.row;
				tmr_sel_o = sdram_pkg::TRCD;
				state_d = ACT_W;
			end
			ACT_W:
			begin
				if (tmr_done_i)
					state_d = req_q.we ? WR : RD;
			end
			RD:
			begin
				cmd_d.op = sdram_pkg::READ;
				cmd_d.bank = req_q.bank;
				cmd_d.addr = sdram_pkg::ADDR_AP | sdram_pkg::sdram_addr_t'(req_q.col);
				tmr_sel_o = sdram_pkg::TCL;
				state_d = RD_W;
			end
			RD_W:
			begin
				if (tmr_done_i)
				begin
					host_ack_d = 1'b1;	// Data valid after CAS latency
					tmr_sel_o = sdram_pkg::TRP;	// Auto precharge still running
					state_d = RECOVER_W;
				end
			end
			WR:
			begin
				cmd_d.op = sdram_pkg::WRITE;
				cmd_d.bank = req_q.bank;
				cmd_d.addr = sdram_pkg::ADDR_AP | sdram_pkg::sdram_addr_t'(req_q.col);
				tmr_sel_o = sdram_pkg::TWR_TRP;
				host_ack_d = 1'b1;
				state_d = RECOVER_W;
			end
			RECOVER_W: if (tmr_done_i) state_d = IDLE;

			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state_q <= IDLE;
			cmd_q <= sdram_pkg::CMD_NOP;
			host_ack_q <= 1'b0;
			rfr_ack_q <= 1'b0;
			init_done_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			cmd_q <= cmd_d;
			host_ack_q <= host_ack_d;
			rfr_ack_q <= rfr_ack_d;
			if (init_clr)
				init_done_q <= 1'b0;
			else if (init_set)
				init_done_q <= 1'b1;
		end
	end

	// Request held stable for the whole access
	always_ff @(posedge clk)
	begin
		if (req_ld)
			req_q <= host_req_i;
	end

	assign cmd_o = cmd_q;
	assign host_ack_o = host_ack_q;
	assign rfr_ack_o = rfr_ack_q;
	assign init_done_o = init_done_q;

endmodule

// File: sdram_delay_timer.sv
module sdram_delay_timer #(
	parameter int INIT_REFRESHES = 8
) (
	input  logic                     clk,
	input  logic                     rst,
	input  sdram_pkg::sdram_timing_t timing_i,
	input  sdram_pkg::timer_sel_e    tmr_sel_i,
	input  logic                     irc_load_i,
	input  logic                     irc_dec_i,
	output logic                     tmr_done_o,
	output logic                     irc_done_o
);

	localparam int IRC_W = $clog2(INIT_REFRESHES + 1);

	logic [7:0] timer_q;
	logic [7:0] load_val;
	logic load;
	logic done_q;
	logic [IRC_W-1:0] irc_cnt_q;
	logic irc_done_q;

	assign load = tmr_sel_i != sdram_pkg::NONE;

	// Field select
	always_comb
	begin
		case (tmr_sel_i)
			sdram_pkg::TRP:     load_val = 8'(timing_i.trp);
			sdram_pkg::TRCD:    load_val = 8'(timing_i.trcd);
			sdram_pkg::TCL:     load_val = 8'(timing_i.tcl);
			sdram_pkg::TRFC:    load_val = 8'(timing_i.trfc);
			sdram_pkg::TWR_TRP: load_val = 8'(timing_i.twr) + 8'(timing_i.trp);	// Write recovery
			default:            load_val = '0;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			timer_q <= '0;
			done_q <= 1'b0;
		end
		else
		begin
			if (load)
				timer_q <= load_val;
			else if (timer_q != '0)
				timer_q <= timer_q - 8'd1;
			done_q <= timer_q == '0 && !load;	// Forced low by a load
		end
	end

	////////////////////////////////
	// Init refresh counter

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			irc_cnt_q <= IRC_W'(INIT_REFRESHES);
			irc_done_q <= 1'b0;
		end
		else
		begin
			if (irc_load_i)
				irc_cnt_q <= IRC_W'(INIT_REFRESHES);
			else if (irc_dec_i && irc_cnt_q != '0)
				irc_cnt_q <= irc_cnt_q - 1'b1;
			irc_done_q <= irc_cnt_q == '0 && !irc_load_i;
		end
	end

	assign tmr_done_o = done_q;
	assign irc_done_o = irc_done_q;

endmodule

// File: sdram_pkg.sv
package sdram_pkg;

	////////////////////////////////
	// SDRAM command codes and field widths

	// {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		NOP          = 4'b0111,
		PRECHARGE    = 4'b0010,
		ACTIVATE     = 4'b0011,
		READ         = 4'b0101,
		WRITE        = 4'b0100,
		AUTO_REFRESH = 4'b0001,
		LOAD_MODE    = 4'b0000
	} sdram_op_e;

	typedef logic [1:0]  bank_t;
	typedef logic [12:0] row_t;
	typedef logic [9:0]  col_t;
	typedef logic [12:0] sdram_addr_t;
	typedef logic [3:0]  tfield_t;	// Cycles

	localparam int AP_BIT = 10;	// Auto precharge / all banks
	localparam sdram_addr_t ADDR_AP = sdram_addr_t'(1) << AP_BIT;

	typedef struct packed {
		logic [11:0] rsvd;
		tfield_t     twr;
		tfield_t     trfc;
		tfield_t     tcl;
		tfield_t     trcd;
		tfield_t     trp;	// Bits 3:0
	} sdram_timing_t;

	typedef enum logic [2:0] {NONE, TRP, TRCD, TCL, TRFC, TWR_TRP} timer_sel_e;

	typedef struct packed {
		sdram_op_e   op;
		bank_t       bank;
		sdram_addr_t addr;
	} sdram_cmd_t;

	localparam sdram_cmd_t CMD_NOP = '{op: NOP, bank: '0, addr: '0};

	typedef struct packed {
		logic we;
		bank_t bank;
		row_t row;
		col_t col;
	} host_req_t;

	////////////////////////////////
	// Register bus

	typedef logic [3:0]  axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [1:0]  axil_resp_t;

	localparam axil_resp_t RESP_OKAY = 2'b00;

	localparam axil_addr_t REG_TIMING = 4'h0;
	localparam axil_addr_t REG_MODE   = 4'h4;
	localparam axil_addr_t REG_CTRL   = 4'h8;

	typedef struct packed {
		logic       awvalid;
		axil_addr_t awaddr;
		logic       wvalid;
		axil_data_t wdata;
		logic [3:0] wstrb;
		logic       bready;
		logic       arvalid;
		axil_addr_t araddr;
		logic       rready;
	} axil_req_t;

	typedef struct packed {
		logic       awready;
		logic       wready;
		logic       bvalid;
		axil_resp_t bresp;
		logic       arready;
		logic       rvalid;
		axil_data_t rdata;
		axil_resp_t rresp;
	} axil_rsp_t;

endpackage

// File: sdram_seq_checker.sv
module sdram_seq_checker (
	input logic                  clk,
	input logic                  rst,
	input logic                  host_ack_i,
	input logic                  rfr_ack_i,
	input logic                  init_done_i,
	input sdram_pkg::sdram_cmd_t cmd_i
);

	int unsigned fail_count = 0;	// Read by the testbench

	////////////////////////////////
	// Acknowledge pulses

	host_ack_pulse: assert property (@(posedge clk) disable iff (rst)
		host_ack_i |=> !host_ack_i)
	else
	begin
		$error("host_ack_o held for two cycles");
		fail_count++;
	end

	rfr_ack_pulse: assert property (@(posedge clk) disable iff (rst)
		rfr_ack_i |=> !rfr_ack_i)
	else
	begin
		$error("rfr_ack_o held for two cycles");
		fail_count++;
	end

	// Only init commands before init is done
	pre_init_cmds: assert property (@(posedge clk) disable iff (rst)
		!init_done_i |-> cmd_i.op inside {sdram_pkg::NOP, sdram_pkg::PRECHARGE,
			sdram_pkg::AUTO_REFRESH, sdram_pkg::LOAD_MODE})
	else
	begin
		$error("Access command issued before init done");
		fail_count++;
	end

	pre_init_act: assert property (@(posedge clk) disable iff (rst)
		!init_done_i |-> cmd_i.op != sdram_pkg::ACTIVATE)
	else
	begin
		$error("ACTIVATE issued before init done");
		fail_count++;
	end

endmodule

bind sdram_cmd_fsm sdram_seq_checker fsm_checker_i (
	.clk         (clk),
	.rst         (rst),
	.host_ack_i  (host_ack_o),
	.rfr_ack_i   (rfr_ack_o),
	.init_done_i (init_done_o),
	.cmd_i       (cmd_o)
);

// File: sdram_seq_golden.txt
# kind a0 a1 a2 a3 n cmd... (hex). WR: addr data, RD: addr expected, INIT/RFR: no args
# ACC/EARLY/BOTH: we bank row col. Each cmd is {op[3:0], bank[1:0], addr[12:0]}
RD 8 0 0 0 0
RD c 0 0 0 0
WR 0 00024232 0 0 0
RD 0 00024232 0 0 0
WR 4 00000233 0 0 0
RD 4 00000233 0 0 0
RD 8 0 0 0 0
EARLY 1 1 0123 045 c 10400 08000 08000 08000 08000 08000 08000 08000 08000 00233 1A123 22445
RD 8 2 0 0 0
ACC 1 2 1ABC 3FF 2 1DABC 247FF
ACC 0 3 0FFF 200 2 1EFFF 2E600
RFR 0 0 0 0 2 10400 08000
BOTH 0 1 0555 155 4 10400 08000 1A555 2A555
WR 0 00015323 0 0 0
WR 4 00000030 0 0 0
RD 0 00015323 0 0 0
INIT 0 0 0 0 a 10400 08000 08000 08000 08000 08000 08000 08000 08000 00030
RD 8 2 0 0 0
ACC 0 0 0000 000 2 18000 28400
BOTH 1 2 0AAA 0AA 4 10400 08000 1CAAA 244AA

// File: sdram_seq_top.sv
module sdram_seq_top #(
	parameter int INIT_REFRESHES = 8
) (
	input  logic                  clk,
	input  logic                  rst,
	input  sdram_pkg::axil_req_t  axil_req_i,
	input  logic                  host_req_valid_i,
	input  sdram_pkg::host_req_t  host_req_i,
	input  logic                  rfr_req_i,
	output sdram_pkg::axil_rsp_t  axil_rsp_o,
	output logic                  host_ack_o,
	output logic                  rfr_ack_o,
	output sdram_pkg::sdram_cmd_t sdram_cmd_o
);

	sdram_pkg::sdram_timing_t timing;
	sdram_pkg::sdram_addr_t mode;
	sdram_pkg::timer_sel_e tmr_sel;
	logic init_start;
	logic init_done;
	logic irc_load;
	logic irc_dec;
	logic tmr_done;
	logic irc_done;

	////////////////////////////////
	// Host register block

	sdram_cfg_regs cfg_regs_i (
		.clk          (clk),
		.rst          (rst),
		.axil_req_i   (axil_req_i),
		.init_done_i  (init_done),
		.axil_rsp_o   (axil_rsp_o),
		.timing_o     (timing),
		.mode_o       (mode),
		.init_start_o (init_start)
	);

	// Interval timer and init refresh count
	sdram_delay_timer #(
		.INIT_REFRESHES (INIT_REFRESHES)
	) delay_timer_i (
		.clk        (clk),
		.rst        (rst),
		.timing_i   (timing),
		.tmr_sel_i  (tmr_sel),
		.irc_load_i (irc_load),
		.irc_dec_i  (irc_dec),
		.tmr_done_o (tmr_done),
		.irc_done_o (irc_done)
	);

	sdram_cmd_fsm cmd_fsm_i (
		.clk              (clk),
		.rst              (rst),
		.init_start_i     (init_start),
		.mode_i           (mode),
		.host_req_valid_i (host_req_valid_i),
		.host_req_i       (host_req_i),
		.rfr_req_i        (rfr_req_i),
		.tmr_done_i       (tmr_done),
		.irc_done_i       (irc_done),
		.host_ack_o       (host_ack_o),
		.rfr_ack_o        (rfr_ack_o),
		.init_done_o      (init_done),
		.cmd_o            (sdram_cmd_o),
		.tmr_sel_o        (tmr_sel),
		.irc_load_o       (irc_load),
		.irc_dec_o        (irc_dec)
	);

endmodule

// File: tb_sdram_seq.sv
module tb_sdram_seq;

	localparam int QUIET = 40;	// Cycles without commands that end an operation
	localparam int OP_BUDGET = 200;

	logic clk;
	logic rst;
	sdram_pkg::axil_req_t axil_req;
	sdram_pkg::axil_rsp_t axil_rsp;
	logic host_req_valid;
	sdram_pkg::host_req_t host_req;
	logic rfr_req;
	logic host_ack;
	logic rfr_ack;
	sdram_pkg::sdram_cmd_t sdram_cmd;

	// Golden operations
	string op_kind[$];
	logic [3:0][31:0] op_args[$];
	int op_first[$];
	int op_count[$];
	sdram_pkg::sdram_cmd_t exp_cmds[$];
	bit loaded;

	// Recorded during the current operation
	sdram_pkg::sdram_cmd_t got_cmds[$];
	int got_cyc[$];
	int host_ack_cyc[$];
	int rfr_ack_cyc[$];
	int cycle;
	int last_cmd_cycle;

	sdram_pkg::sdram_timing_t timing;	// Last value written to REG_TIMING
	int value_errors;
	int other_errors;
	logic [31:0] lcg_state;

	sdram_seq_top #(
		.INIT_REFRESHES (8)
	) dut_i (
		.clk              (clk),
		.rst              (rst),
		.axil_req_i       (axil_req),
		.host_req_valid_i (host_req_valid),
		.host_req_i       (host_req),
		.rfr_req_i        (rfr_req),
		.axil_rsp_o       (axil_rsp),
		.host_ack_o       (host_ack),
		.rfr_ack_o        (rfr_ack),
		.sdram_cmd_o      (sdram_cmd)
	);

	always
	begin
		#2 clk = 1'b1;
		#2 clk = 1'b0;
	end

	always @(posedge clk)
		cycle++;

	////////////////////////////////
	// Command and ack recorder

	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (sdram_cmd.op != sdram_pkg::NOP)
			begin
				got_cmds.push_back(sdram_cmd);
				got_cyc.push_back(cycle);
				last_cmd_cycle = cycle;
			end
			if (host_ack)
				host_ack_cyc.push_back(cycle);
			if (rfr_ack)
				rfr_ack_cyc.push_back(cycle);
		end
	end

	function automatic int next_gap();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[18:16]);	// 0 to 7
	endfunction

	// Least spacing after a command of this kind
	function automatic int min_gap(input sdram_pkg::sdram_op_e op);
		case (op)
			sdram_pkg::PRECHARGE:    return int'(timing.trp) + 1;
			sdram_pkg::AUTO_REFRESH: return int'(timing.trfc) + 1;
			sdram_pkg::ACTIVATE:     return int'(timing.trcd) + 1;
			default:                 return 1;
		endcase
	endfunction

	task automatic check_cmd(input string name, input sdram_pkg::sdram_cmd_t exp,
		input sdram_pkg::sdram_cmd_t act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %s bank %0d addr %h, actual %s bank %0d addr %h",
				name, exp.op.name(), exp.bank, exp.addr, act.op.name(), act.bank, act.addr);
			value_errors++;
		end
	endtask

	task automatic check_reg(input string name, input sdram_pkg::axil_data_t exp,
		input sdram_pkg::axil_data_t act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_resp(input string name, input sdram_pkg::axil_resp_t exp,
		input sdram_pkg::axil_resp_t act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_ack(input string name, input string what, input int exp, input int act);
		if (act != exp)
		begin
			$display("FAILED %s %s: expected %0d, actual %0d", name, what, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
		begin
			$display("FAILED %s command count: expected %0d, actual %0d", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic load_golden(output bit ok);
		int fd;
		int code;
		int n;
		string kind;
		string rest;
		logic [31:0] a0, a1, a2, a3;
		logic [18:0] word;
		ok = 1'b0;
		fd = $fopen("sdram_seq_golden.txt", "r");
		if (fd != 0)
		begin
			ok = 1'b1;
			while ($fscanf(fd, "%s", kind) == 1)
			begin
				if (kind[0] == "#")
					code = $fgets(rest, fd);	// Column description
				else
				begin
					code = $fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, n);
					if (code != 5)
						ok = 1'b0;
					op_kind.push_back(kind);
					op_args.push_back({a3, a2, a1, a0});
					op_first.push_back(exp_cmds.size());
					op_count.push_back(n);
					repeat (n)
					begin
						code = $fscanf(fd, "%h", word);
						exp_cmds.push_back(sdram_pkg::sdram_cmd_t'(word));
					end
				end
			end
			$fclose(fd);
			loaded = ok;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	////////////////////////////////
	// AXI4-Lite host

	task automatic reg_write(input string name, input sdram_pkg::axil_addr_t addr,
		input sdram_pkg::axil_data_t data);
		axil_req.awvalid = 1'b1;
		axil_req.awaddr = addr;
		axil_req.wvalid = 1'b1;
		axil_req.wdata = data;
		axil_req.wstrb = 4'hf;
		axil_req.bready = 1'b1;
		do
			@(negedge clk);
		while (!axil_rsp.awready);
		if (!axil_rsp.wready)
		begin
			$display("In %s wready did not rise together with awready", name);
			other_errors++;
		end
		@(posedge clk);
		#1;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		do
			@(negedge clk);
		while (!axil_rsp.bvalid);
		check_resp($sformatf("%s bresp", name), 2'b00, axil_rsp.bresp);	// OKAY
		@(posedge clk);
		#1;
		axil_req.bready = 1'b0;
	endtask

	task automatic reg_read(input string name, input sdram_pkg::axil_addr_t addr,
		output sdram_pkg::axil_data_t data);
		axil_req.arvalid = 1'b1;
		axil_req.araddr = addr;
		axil_req.rready = 1'b1;
		do
			@(negedge clk);
		while (!axil_rsp.arready);
		@(posedge clk);
		#1;
		axil_req.arvalid = 1'b0;
		do
			@(negedge clk);
		while (!axil_rsp.rvalid);
		data = axil_rsp.rdata;
		check_resp($sformatf("%s rresp", name), 2'b00, axil_rsp.rresp);	// OKAY
		@(posedge clk);
		#1;
		axil_req.rready = 1'b0;
	endtask

	// Hold each raised request until its ack
	task automatic serve(input bit want_host, input bit want_rfr);
		bit host_seen;
		bit rfr_seen;
		bit h;
		bit r;
		host_seen = !want_host;
		rfr_seen = !want_rfr;
		while (!(host_seen && rfr_seen))
		begin
			@(negedge clk);
			h = host_ack;
			r = rfr_ack;
			@(posedge clk);
			#1;
			if (h)
			begin
				host_req_valid = 1'b0;
				host_seen = 1'b1;
			end
			if (r)
			begin
				rfr_req = 1'b0;
				rfr_seen = 1'b1;
			end
		end
	endtask

	task automatic wait_quiet();
		int start;
		start = cycle;
		do
			@(negedge clk);
		while (cycle - start < QUIET || cycle - last_cmd_cycle < QUIET);
		@(posedge clk);
		#1;
	endtask

	task automatic check_op(input int idx, input string name, input bit want_host,
		input bit want_rfr);
		int first;
		int n;
		int gap;
		first = op_first[idx];
		n = op_count[idx];
		check_count(name, n, got_cmds.size());
		for (int i = 0; i < n && i < got_cmds.size(); i++)
		begin
			check_cmd($sformatf("%s cmd %0d", name, i), exp_cmds[first + i], got_cmds[i]);
			gap = i > 0 ? got_cyc[i] - got_cyc[i - 1] : 0;
			if (i > 0 && gap < min_gap(got_cmds[i - 1].op))
			begin
				$display("Command %0d of %s came only %0d cycles after the previous one",
					i, name, gap);
				other_errors++;
			end
		end
		check_ack(name, "host ack pulses", int'(want_host), host_ack_cyc.size());
		check_ack(name, "refresh ack pulses", int'(want_rfr), rfr_ack_cyc.size());
		for (int i = 0; i < got_cmds.size(); i++)
		begin
			if (got_cmds[i].op == sdram_pkg::WRITE && host_ack_cyc.size() == 1)
				check_ack(name, "write ack cycle", got_cyc[i], host_ack_cyc[0]);
			if (got_cmds[i].op == sdram_pkg::AUTO_REFRESH && rfr_ack_cyc.size() == 1)
				check_ack(name, "refresh ack cycle", got_cyc[i], rfr_ack_cyc[0]);
			if (got_cmds[i].op == sdram_pkg::READ && host_ack_cyc.size() == 1 &&
				host_ack_cyc[0] - got_cyc[i] < int'(timing.tcl) + 1)
			begin
				$display("Read ack in %s came before the CAS latency had passed", name);
				other_errors++;
			end
		end
	endtask

	task automatic run_op(input int idx);
		string kind;
		string name;
		logic [3:0][31:0] a;
		sdram_pkg::axil_data_t rd;
		bit want_host;
		bit want_rfr;
		kind = op_kind[idx];
		a = op_args[idx];
		name = $sformatf("op %0d %s", idx + 1, kind);
		want_host = kind == "ACC" || kind == "EARLY" || kind == "BOTH";
		want_rfr = kind == "RFR" || kind == "BOTH";
		got_cmds.delete();
		got_cyc.delete();
		host_ack_cyc.delete();
		rfr_ack_cyc.delete();
		host_req.we = a[0][0];
		host_req.bank = a[1][1:0];
		host_req.row = a[2][12:0];
		host_req.col = a[3][9:0];
		host_req_valid = want_host;	// Raised together
		rfr_req = want_rfr;
		if (kind == "WR")
		begin
			reg_write(name, a[0][3:0], a[1]);
			if (a[0][3:0] == sdram_pkg::REG_TIMING)
				timing = a[1];
		end
		else if (kind == "RD")
		begin
			reg_read(name, a[0][3:0], rd);
			check_reg(name, a[1], rd);
		end
		else if (kind == "INIT" || kind == "EARLY")
		begin
			if (kind == "EARLY")
				idle_cycles(8);	// Request pending, no command yet
			reg_write(name, sdram_pkg::REG_CTRL, 32'd1);
		end
		else if (!want_host && !want_rfr)
		begin
			$display("Unknown operation %s in golden file", kind);
			other_errors++;
		end
		serve(want_host, want_rfr);
		while (got_cmds.size() < op_count[idx])
			@(negedge clk);
		wait_quiet();
		check_op(idx, name, want_host, want_rfr);
	endtask

	initial
	begin
		wait (loaded);
		repeat (op_kind.size() * OP_BUDGET) @(posedge clk);
		$display("Timeout: operations still running after %0d cycles", op_kind.size() * OP_BUDGET);
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		bit ok;
		int assert_errors;
		clk = 1'b0;
		rst = 1'b1;
		axil_req = '0;
		host_req_valid = 1'b0;
		host_req = '0;
		rfr_req = 1'b0;
		cycle = 0;
		last_cmd_cycle = 0;
		value_errors = 0;
		other_errors = 0;
		lcg_state = 32'd15;
		timing = '1;	// Reset value of REG_TIMING
		load_golden(ok);
		if (!ok)
		begin
			$display("Golden file sdram_seq_golden.txt missing or malformed");
			$display("Checks failed");
			$finish;
		end
		else
		begin
			repeat (2) @(posedge clk);
			#1;
			rst = 1'b0;
			for (int i = 0; i < op_kind.size(); i++)
			begin
				idle_cycles(next_gap());
				run_op(i);
			end
			assert_errors = dut_i.cmd_fsm_i.fsm_checker_i.fail_count;
			$display("Errors: %0d wrong values, %0d other, %0d assertions",
				value_errors, other_errors, assert_errors);
			if (value_errors + other_errors + assert_errors == 0)
				$display("All checks passed");
			else
				$display("Checks failed");
			$finish;
		end
	end

endmodule
